// File: verilog/l2_axi_pkg.sv
// shared types and constants for the l2 arbiter to AXI4 bridge
// request format, operation union, AXI channel payloads and atomic codes
`default_nettype none

package l2_axi_pkg;

    // requester id width and queue depths
    localparam int L2_ID_W     = 2;
    localparam int REQ_DEPTH   = 4;
    localparam int WDATA_DEPTH = 16;

    // atomic functions, RISC-V funct5 encoding
    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_fn_t;

    // burst length for plain requests, atomic function otherwise
    typedef union packed {
        logic [4:0] burst_len;
        amo_fn_t    amo_fn;
    } l2_op_u;

    typedef struct packed {
        logic [29:0]        addr;
        logic [3:0]         be;
        logic               rnw;
        logic               is_amo;
        l2_op_u             op;
        logic [L2_ID_W-1:0] id;
    } l2_request_t;

    // read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [5:0]  id;
    } axi_ar_t;

    // write address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [5:0]  id;
        logic        last;
    } axi_r_t;

    // read data returned to the requester
    typedef struct packed {
        logic [31:0]        data;
        logic [L2_ID_W-1:0] id;
    } l2_rd_t;

endpackage

`default_nettype wire

// File: verilog/l2_fifo.sv
// small synchronous FIFO with a type parameter
// head is read combinationally from the oldest entry
`default_nettype none

module l2_fifo #(
    parameter type data_t = logic [31:0],
    parameter int  DEPTH  = 4
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  push,
    input  wire data_t push_data,
    output logic       full,
    input  wire logic  pop,
    output logic       valid,
    output data_t      head
);

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH):0]   count_t;

    data_t  mem [DEPTH];
    ptr_t   rd_ptr;
    ptr_t   wr_ptr;
    count_t count;
    logic   do_push;
    logic   do_pop;

    assign valid = (count != '0);
    assign full  = (count == count_t'(DEPTH));
    assign head  = mem[rd_ptr];

    // pushes while full are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy only moves when exactly one side fires
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/amo_alu.sv
// atomic ALU
// new memory word from the loaded word and the request operand
`default_nettype none

module amo_alu (
    input  wire l2_axi_pkg::amo_fn_t amo_fn,
    input  wire logic [31:0]         load,
    input  wire logic [31:0]         operand,
    output logic [31:0]              result
);

    import l2_axi_pkg::*;

    logic signed_lt;
    logic unsigned_lt;

    // two's complement vs plain compare
    assign signed_lt   = ($signed(load) < $signed(operand));
    assign unsigned_lt = (load < operand);

    always_comb begin
        case (amo_fn)
            AMO_SWAP: begin
                result = operand;
            end
            AMO_ADD: begin
                result = load + operand;
            end
            AMO_XOR: begin
                result = load ^ operand;
            end
            AMO_AND: begin
                result = load & operand;
            end
            AMO_OR: begin
                result = load | operand;
            end
            AMO_MIN: begin
                result = signed_lt ? load : operand;
            end
            AMO_MAX: begin
                result = signed_lt ? operand : load;
            end
            AMO_MINU: begin
                result = unsigned_lt ? load : operand;
            end
            AMO_MAXU: begin
                result = unsigned_lt ? operand : load;
            end
            default: begin
                // unknown code leaves memory unchanged
                result = load;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/axi_to_arb.sv
// request queue to AXI4 bridge
// sequences reads, write bursts and atomic read-modify-writes onto AR/AW/W
`default_nettype none

module axi_to_arb (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    head_valid,
    input  wire l2_axi_pkg::l2_request_t head,
    output logic                         req_pop,
    input  wire logic                    wd_valid,
    input  wire logic [31:0]             wd,
    output logic                         wd_pop,
    output logic                         ar_valid,
    output l2_axi_pkg::axi_ar_t          ar,
    input  wire logic                    ar_ready,
    output logic                         aw_valid,
    output l2_axi_pkg::axi_aw_t          aw,
    input  wire logic                    aw_ready,
    output logic                         w_valid,
    output l2_axi_pkg::axi_w_t           w,
    input  wire logic                    w_ready,
    input  wire logic                    r_valid,
    input  wire l2_axi_pkg::axi_r_t      r,
    input  wire logic                    b_valid,
    output logic                         rd_valid,
    output l2_axi_pkg::l2_rd_t           rd,
    output l2_axi_pkg::amo_fn_t          amo_fn,
    output logic [31:0]                  load,
    output logic [31:0]                  operand,
    input  wire logic [31:0]             result
);

    import l2_axi_pkg::*;

    typedef enum logic [1:0] {
        RMW_IDLE,
        RMW_READ,
        RMW_WRITE,
        RMW_RESP
    } rmw_state_t;

    rmw_state_t  rmw_state;
    logic        addr_done;
    logic        write_in_progress;
    logic [4:0]  beat_cnt;
    logic [3:0]  wr_pending;
    logic [31:0] amo_result_r;

    logic [4:0]  burst_len;
    logic [29:0] base_addr;
    logic [5:0]  amo_rid;
    logic        plain_read;
    logic        plain_write;
    logic        rmw_wait;
    logic        amo_write_ready;
    logic        amo_beat;
    logic        ar_start;
    logic        ar_fire;
    logic        write_req;
    logic        w_fire;
    logic        last_beat;

    // op field decode; atomics are always a single word
    assign burst_len   = head.is_amo ? 5'd0 : head.op.burst_len;
    assign amo_fn      = head.op.amo_fn;
    assign plain_read  = head.rnw & ~head.is_amo;
    assign plain_write = ~head.rnw & ~head.is_amo;

    // align down to the burst size
    assign base_addr = head.addr & ~30'(burst_len);

    // atomic reads carry a flag bit in the AXI id to find their beat
    assign amo_rid = 6'({1'b1, head.id});

    assign rmw_wait        = (rmw_state == RMW_RESP);
    assign amo_write_ready = (rmw_state == RMW_WRITE);
    assign amo_beat        = r_valid && (r.id == amo_rid);

    // read address channel
    assign ar.addr = {base_addr, 2'b00};
    assign ar.len  = 8'(burst_len);
    assign ar.id   = head.is_amo ? amo_rid : 6'(head.id);
    assign ar_fire = ar_valid & ar_ready;

    // atomics wait for their operand before reading
    assign ar_start = head_valid & ~addr_done & ~rmw_wait &
                      (plain_read | (head.is_amo & wd_valid & (rmw_state == RMW_IDLE)));

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid <= 1'b0;
        end else if (ar_fire) begin
            ar_valid <= 1'b0;
        end else if (ar_start) begin
            ar_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_done <= 1'b0;
        end else if (req_pop) begin
            addr_done <= 1'b0;
        end else if (ar_fire) begin
            addr_done <= 1'b1;
        end
    end

    // write address and data channels
    assign write_req = head_valid & wd_valid & ~rmw_wait & (plain_write | amo_write_ready);
    assign aw_valid  = write_req & ~write_in_progress;
    assign aw.addr   = {base_addr, 2'b00};
    assign aw.len    = 8'(burst_len);

    assign w_valid   = write_in_progress & wd_valid;
    assign last_beat = w_valid && (beat_cnt == burst_len);
    assign w_fire    = w_valid & w_ready;
    assign w.data    = head.is_amo ? amo_result_r : wd;
    assign w.strb    = head.is_amo ? 4'hf : head.be;
    assign w.last    = last_beat;
    assign wd_pop    = w_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            write_in_progress <= 1'b0;
        end else if (w_fire && last_beat) begin
            write_in_progress <= 1'b0;
        end else if (aw_valid && aw_ready) begin
            write_in_progress <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (w_fire && last_beat) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // plain reads leave on AR, everything else on the final W beat
    assign req_pop = (ar_fire & ~head.is_amo) | (w_fire & last_beat);

    // bursts whose write response has not come back yet
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pending <= '0;
        end else begin
            case ({w_fire & last_beat, b_valid})
                2'b10:   wr_pending <= wr_pending + 1'b1;
                2'b01:   wr_pending <= wr_pending - 1'b1;
                default: wr_pending <= wr_pending;
            endcase
        end
    end

    // read-modify-write sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            rmw_state <= RMW_IDLE;
        end else begin
            case (rmw_state)
                RMW_IDLE: begin
                    if (ar_fire && head.is_amo) begin
                        rmw_state <= RMW_READ;
                    end
                end
                RMW_READ: begin
                    if (amo_beat) begin
                        rmw_state <= RMW_WRITE;
                    end
                end
                RMW_WRITE: begin
                    if (w_fire && last_beat) begin
                        rmw_state <= RMW_RESP;
                    end
                end
                default: begin
                    // hold the next head until all writes are acknowledged
                    if (wr_pending == '0) begin
                        rmw_state <= RMW_IDLE;
                    end
                end
            endcase
        end
    end

    assign load    = r.data;
    assign operand = wd;

    always_ff @(posedge clk) begin
        if (rmw_state == RMW_READ && amo_beat) begin
            amo_result_r <= result;
        end
    end

    // read data goes straight back, no stall possible
    assign rd_valid = r_valid;
    assign rd.data  = r.data;
    assign rd.id    = r.id[L2_ID_W-1:0];

endmodule

`default_nettype wire

// File: verilog/l2_axi_bridge_top.sv
// l2 arbiter to AXI4 bridge top level
// request and write data queues feeding the bridge and atomic ALU
`default_nettype none

module l2_axi_bridge_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    req_push,
    input  wire l2_axi_pkg::l2_request_t req,
    output logic                         req_full,
    input  wire logic                    wdata_push,
    input  wire logic [31:0]             wdata,
    output logic                         wdata_full,
    output logic                         rd_valid,
    output l2_axi_pkg::l2_rd_t           rd,
    output logic                         ar_valid,
    output l2_axi_pkg::axi_ar_t          ar,
    input  wire logic                    ar_ready,
    output logic                         aw_valid,
    output l2_axi_pkg::axi_aw_t          aw,
    input  wire logic                    aw_ready,
    output logic                         w_valid,
    output l2_axi_pkg::axi_w_t           w,
    input  wire logic                    w_ready,
    input  wire logic                    r_valid,
    input  wire l2_axi_pkg::axi_r_t      r,
    input  wire logic                    b_valid
);

    import l2_axi_pkg::*;

    l2_request_t head;
    logic        head_valid;
    logic        req_pop;
    logic [31:0] wd;
    logic        wd_valid;
    logic        wd_pop;
    amo_fn_t     amo_fn;
    logic [31:0] load;
    logic [31:0] operand;
    logic [31:0] result;

    l2_fifo #(
        .data_t (l2_request_t),
        .DEPTH  (REQ_DEPTH)
    ) req_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (req_push),
        .push_data (req),
        .full      (req_full),
        .pop       (req_pop),
        .valid     (head_valid),
        .head      (head)
    );

    // one word per write beat, one operand word per atomic
    l2_fifo #(
        .data_t (logic [31:0]),
        .DEPTH  (WDATA_DEPTH)
    ) wdata_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (wdata_push),
        .push_data (wdata),
        .full      (wdata_full),
        .pop       (wd_pop),
        .valid     (wd_valid),
        .head      (wd)
    );

    axi_to_arb i_axi_to_arb (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head       (head),
        .req_pop    (req_pop),
        .wd_valid   (wd_valid),
        .wd         (wd),
        .wd_pop     (wd_pop),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .ar_ready   (ar_ready),
        .aw_valid   (aw_valid),
        .aw         (aw),
        .aw_ready   (aw_ready),
        .w_valid    (w_valid),
        .w          (w),
        .w_ready    (w_ready),
        .r_valid    (r_valid),
        .r          (r),
        .b_valid    (b_valid),
        .rd_valid   (rd_valid),
        .rd         (rd),
        .amo_fn     (amo_fn),
        .load       (load),
        .operand    (operand),
        .result     (result)
    );

    amo_alu i_amo_alu (
        .amo_fn  (amo_fn),
        .load    (load),
        .operand (operand),
        .result  (result)
    );

endmodule

`default_nettype wire

// File: testbench/l2_axi_bridge_checker.sv
// AXI channel protocol assertions, bound into the bridge top level
`default_nettype none

module l2_axi_bridge_checker (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                ar_valid,
    input wire logic                ar_ready,
    input wire l2_axi_pkg::axi_ar_t ar,
    input wire logic                aw_valid,
    input wire logic                aw_ready,
    input wire l2_axi_pkg::axi_aw_t aw,
    input wire logic                w_valid,
    input wire logic                w_ready,
    input wire l2_axi_pkg::axi_w_t  w
);

    // a stalled channel keeps valid and payload
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("AR valid or payload changed while stalled");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW valid or payload changed while stalled");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W valid or payload changed while stalled");

    w_last_valid: assert property (@(posedge clk) disable iff (rst) w.last |-> w_valid)
        else $error("w.last high without w_valid");

    reset_quiet: assert property (@(posedge clk) rst |=> !ar_valid && !aw_valid && !w_valid)
        else $error("AXI valid high in the cycle after reset");

endmodule

bind l2_axi_bridge_top l2_axi_bridge_checker i_checker (
    .clk      (clk),
    .rst      (rst),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w)
);

`default_nettype wire

// File: testbench/l2_axi_bridge_tb.sv
// testbench for the l2 arbiter to AXI4 bridge
// random requests against a shadow memory, AXI memory model with back-pressure
`default_nettype none

module l2_axi_bridge_tb;

    import l2_axi_pkg::*;

    localparam logic [31:0] SEED = 32'h6b85_a125;
    localparam int N_RAND = 60;
    // single words, bursts, atomics with their read back, random mix
    localparam int N_REQ = 16 + 16 + 36 + N_RAND;
    localparam int WATCHDOG_CYCLES = N_REQ * 150 + 500;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_push;
    l2_request_t req;
    logic        req_full;
    logic        wdata_push;
    logic [31:0] wdata;
    logic        wdata_full;
    logic        rd_valid;
    l2_rd_t      rd;
    logic        ar_valid;
    axi_ar_t     ar;
    logic        ar_ready;
    logic        aw_valid;
    axi_aw_t     aw;
    logic        aw_ready;
    logic        w_valid;
    axi_w_t      w;
    logic        w_ready;
    logic        r_valid;
    axi_r_t      r;
    logic        b_valid;

    logic [31:0] mem [256];
    logic [31:0] shadow [256];
    l2_rd_t      exp_rd [$];
    axi_ar_t     exp_ar [$];
    axi_aw_t     exp_aw [$];
    axi_aw_t     aw_open [$];
    axi_r_t      r_beats [$];
    logic [7:0]  w_cnt;
    logic        b_due;
    logic        heavy;
    logic [31:0] stim_lfsr;
    logic [31:0] model_lfsr;
    int          errors;
    int          checks;
    int          test_errors;

    l2_axi_bridge_top i_l2_axi_bridge_top (.*);

    always #5 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] model_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            model_lfsr = lfsr_next(model_lfsr);
            v = {v[30:0], model_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] be);
        logic [31:0] m;
        m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~m) | (nw & m);
    endfunction

    function automatic logic [31:0] amo_ref(input amo_fn_t fn, input logic [31:0] old,
                                            input logic [31:0] opd);
        logic [31:0] bias;
        // signed order is the unsigned order with the sign bit flipped
        bias = 32'h8000_0000;
        case (fn)
            AMO_SWAP: return opd;
            AMO_ADD:  return old + opd;
            AMO_XOR:  return old ^ opd;
            AMO_AND:  return old & opd;
            AMO_OR:   return old | opd;
            AMO_MIN:  return ((old ^ bias) <= (opd ^ bias)) ? old : opd;
            AMO_MAX:  return ((old ^ bias) >= (opd ^ bias)) ? old : opd;
            AMO_MINU: return (old <= opd) ? old : opd;
            AMO_MAXU: return (old >= opd) ? old : opd;
            default:  return old;
        endcase
    endfunction

    function automatic amo_fn_t fn_by_index(input int k);
        case (k)
            0:       return AMO_SWAP;
            1:       return AMO_ADD;
            2:       return AMO_XOR;
            3:       return AMO_AND;
            4:       return AMO_OR;
            5:       return AMO_MIN;
            6:       return AMO_MAX;
            7:       return AMO_MINU;
            default: return AMO_MAXU;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("time %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("%s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic check_quiet(input string when);
        check_eq(ar_valid, 1'b0, {"ar_valid ", when});
        check_eq(aw_valid, 1'b0, {"aw_valid ", when});
        check_eq(w_valid, 1'b0, {"w_valid ", when});
        check_eq(rd_valid, 1'b0, {"rd_valid ", when});
        // both queues stay empty
        check_eq(req_full, 1'b0, {"req_full ", when});
        check_eq(wdata_full, 1'b0, {"wdata_full ", when});
    endtask

    task automatic push_req(input l2_request_t q);
        while (req_full) begin
            @(negedge clk);
        end
        req = q;
        req_push = 1'b1;
        @(negedge clk);
        req_push = 1'b0;
    endtask

    task automatic push_wdata(input logic [31:0] d);
        while (wdata_full) begin
            @(negedge clk);
        end
        wdata = d;
        wdata_push = 1'b1;
        @(negedge clk);
        wdata_push = 1'b0;
    endtask

    task automatic issue_write(input logic [7:0] addr, input logic [3:0] be, input logic [4:0] blen);
        l2_request_t q;
        axi_aw_t     e;
        logic [7:0]  base;
        logic [31:0] d;
        base = addr & ~{3'b000, blen};
        e.addr = {22'd0, base, 2'b00};
        e.len = {3'b000, blen};
        exp_aw.push_back(e);
        q = '0;
        q.addr = {22'd0, addr};
        q.be = be;
        q.op.burst_len = blen;
        q.id = L2_ID_W'(stim_bits(L2_ID_W));
        push_req(q);
        for (int i = 0; i <= int'(blen); i++) begin
            d = stim_bits(32);
            shadow[base + 8'(i)] = merge_bytes(shadow[base + 8'(i)], d, be);
            push_wdata(d);
        end
    endtask

    task automatic issue_read(input logic [7:0] addr, input logic [4:0] blen);
        l2_request_t q;
        axi_ar_t     e;
        l2_rd_t      x;
        logic [7:0]  base;
        base = addr & ~{3'b000, blen};
        q = '0;
        q.addr = {22'd0, addr};
        q.rnw = 1'b1;
        q.op.burst_len = blen;
        q.id = L2_ID_W'(stim_bits(L2_ID_W));
        e.addr = {22'd0, base, 2'b00};
        e.len = {3'b000, blen};
        e.id = 6'(q.id);
        exp_ar.push_back(e);
        for (int i = 0; i <= int'(blen); i++) begin
            x.data = shadow[base + 8'(i)];
            x.id = q.id;
            exp_rd.push_back(x);
        end
        push_req(q);
    endtask

    task automatic issue_amo(input logic [7:0] addr, input amo_fn_t fn);
        l2_request_t q;
        axi_ar_t     ea;
        axi_aw_t     ew;
        l2_rd_t      x;
        logic [31:0] opd;
        opd = stim_bits(32);
        q = '0;
        q.addr = {22'd0, addr};
        q.be = 4'hf;
        q.is_amo = 1'b1;
        q.op.amo_fn = fn;
        q.id = L2_ID_W'(stim_bits(L2_ID_W));
        // single word at the exact address, old value comes back
        ea.addr = {22'd0, addr, 2'b00};
        ea.len = 8'd0;
        ea.id = 6'(q.id);
        exp_ar.push_back(ea);
        ew.addr = {22'd0, addr, 2'b00};
        ew.len = 8'd0;
        exp_aw.push_back(ew);
        x.data = shadow[addr];
        x.id = q.id;
        exp_rd.push_back(x);
        shadow[addr] = amo_ref(fn, shadow[addr], opd);
        push_req(q);
        push_wdata(opd);
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (exp_rd.size() != 0 || exp_ar.size() != 0 || exp_aw.size() != 0 ||
                   aw_open.size() != 0 || b_due);
        repeat (3) @(negedge clk);
    endtask

    // AXI memory model, read beats snapshot memory when AR is taken
    task automatic accept_ar();
        axi_ar_t e;
        axi_r_t  b;
        if (exp_ar.size() == 0) begin
            report_fault("AR transfer with no read request outstanding");
        end else begin
            e = exp_ar.pop_front();
            check_eq(ar.addr, e.addr, "AR address");
            check_eq(ar.len, e.len, "AR len");
            check_eq(ar.id[L2_ID_W-1:0], e.id[L2_ID_W-1:0], "AR id");
        end
        for (int i = 0; i <= int'(ar.len); i++) begin
            b.data = mem[ar.addr[9:2] + 8'(i)];
            b.id = ar.id;
            b.last = (i == int'(ar.len));
            r_beats.push_back(b);
        end
    endtask

    task automatic accept_aw();
        axi_aw_t e;
        if (exp_aw.size() == 0) begin
            report_fault("AW transfer with no write request outstanding");
        end else begin
            e = exp_aw.pop_front();
            check_eq(aw.addr, e.addr, "AW address");
            check_eq(aw.len, e.len, "AW len");
        end
        aw_open.push_back(aw);
    endtask

    task automatic accept_w();
        axi_aw_t    cur;
        logic [7:0] idx;
        if (aw_open.size() == 0) begin
            report_fault("W beat arrived before its write address");
        end else begin
            cur = aw_open[0];
            idx = cur.addr[9:2] + w_cnt;
            mem[idx] = merge_bytes(mem[idx], w.data, w.strb);
            check_eq(w.last, (w_cnt == cur.len), "W last");
            if (w_cnt == cur.len) begin
                aw_open.delete(0);
                w_cnt = '0;
                b_due = 1'b1;
            end else begin
                w_cnt = w_cnt + 8'd1;
            end
        end
    endtask

    task automatic check_rd();
        l2_rd_t x;
        if (exp_rd.size() == 0) begin
            report_fault("read data returned with no read outstanding");
        end else begin
            x = exp_rd.pop_front();
            check_eq(rd.data, x.data, "read data");
            check_eq(rd.id, x.id, "read id");
        end
    endtask

    function automatic logic ready_draw();
        return heavy ? (model_bits(2) == 0) : (model_bits(2) != 0);
    endfunction

    task automatic drive_axi();
        ar_ready = ready_draw();
        aw_ready = ready_draw();
        w_ready = ready_draw();
        b_valid = b_due;
        b_due = 1'b0;
        r_valid = 1'b0;
        if (r_beats.size() != 0 && ready_draw()) begin
            r = r_beats.pop_front();
            r_valid = 1'b1;
        end
    endtask

    // handshakes are taken at the rising edge, new inputs on the falling edge
    always begin
        @(posedge clk);
        if (!rst) begin
            if (ar_valid && ar_ready) begin
                accept_ar();
            end
            if (aw_valid && aw_ready) begin
                accept_aw();
            end
            if (w_valid && w_ready) begin
                accept_w();
            end
            if (rd_valid) begin
                check_rd();
            end
        end
        @(negedge clk);
        drive_axi();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the bridge stopped making progress",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [7:0] addrs [8];
        logic [7:0] addr;
        logic [4:0] blen;
        logic [1:0] kind;

        rst = 1'b1;
        req_push = 1'b0;
        req = '0;
        wdata_push = 1'b0;
        wdata = '0;
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        b_valid = 1'b0;
        b_due = 1'b0;
        w_cnt = '0;
        heavy = 1'b0;
        errors = 0;
        checks = 0;
        test_errors = 0;
        stim_lfsr = SEED;
        model_lfsr = SEED;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i) * 32'h9e37_79b9 ^ 32'h0f1e_2d3c;
            shadow[i] = mem[i];
        end

        // pushes late in reset must not reach the AXI side
        req.addr = 30'd5;
        req.be = 4'hf;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            check_quiet("in reset");
            req_push = (c >= 7);
            wdata_push = (c >= 7);
        end
        rst = 1'b0;
        req_push = 1'b0;
        wdata_push = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_quiet("after reset");
        end
        end_test("reset");

        for (int i = 0; i < 8; i++) begin
            addrs[i] = 8'(stim_bits(8));
            issue_write(addrs[i], 4'(stim_bits(4)), 5'd0);
        end
        for (int i = 0; i < 8; i++) begin
            issue_read(addrs[i], 5'd0);
        end
        wait_idle();
        end_test("single word");

        for (int round = 0; round < 2; round++) begin
            for (int k = 1; k <= 4; k++) begin
                blen = 5'((1 << k) - 1);
                addr = 8'(stim_bits(8));
                issue_write(addr, 4'(stim_bits(4)), blen);
                issue_read(addr, blen);
            end
        end
        wait_idle();
        end_test("bursts");

        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 9; k++) begin
                addr = 8'(stim_bits(8));
                issue_amo(addr, fn_by_index(k));
                issue_read(addr, 5'd0);
            end
        end
        wait_idle();
        end_test("atomics");

        heavy = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            kind = 2'(stim_bits(2));
            addr = 8'(stim_bits(8));
            blen = 5'((1 << (stim_bits(3) % 5)) - 1);
            if (kind < 2'd2) begin
                issue_read(addr, blen);
            end else if (kind == 2'd2) begin
                issue_write(addr, 4'(stim_bits(4)), blen);
            end else begin
                issue_amo(addr, fn_by_index(int'(stim_bits(4) % 9)));
            end
        end
        wait_idle();
        heavy = 1'b0;
        for (int i = 0; i < 256; i++) begin
            check_eq(mem[i], shadow[i], "final memory word");
        end
        end_test("back-pressure");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
verilog/l2_axi_pkg.sv
verilog/l2_fifo.sv
verilog/amo_alu.sv
verilog/axi_to_arb.sv
verilog/l2_axi_bridge_top.sv
testbench/l2_axi_bridge_checker.sv
testbench/l2_axi_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the bridge testbench with Verilator and runs it
# the run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module l2_axi_bridge_tb -f src.f -o l2_axi_bridge_sim \
    && ./obj_dir/l2_axi_bridge_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }

cat sim.log
grep -qx "Testbench passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
